//--- src/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and ALU codes
// Vector typedefs and pipeline records
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [4:0]           alu_op_t;
    typedef logic [4:0]           shamt_t;
    typedef logic [16:0]          imm_t;

    // Primary opcodes, insn[31:27]
    localparam logic [4:0] OP_RTYPE = 5'd0;
    localparam logic [4:0] OP_J     = 5'd1;
    localparam logic [4:0] OP_BNE   = 5'd2;
    localparam logic [4:0] OP_JAL   = 5'd3;
    localparam logic [4:0] OP_JR    = 5'd4;
    localparam logic [4:0] OP_ADDI  = 5'd5;
    localparam logic [4:0] OP_BLT   = 5'd6;
    localparam logic [4:0] OP_SW    = 5'd7;
    localparam logic [4:0] OP_LW    = 5'd8;

    // ALU function codes, insn[6:2] for R-type
    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_LINK = 5'd31;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    use_imm;
        logic    is_bne;
        logic    is_blt;
        logic    is_jump;
        logic    is_jal;
        logic    is_jr;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc_next;
        word_t insn;
    } fd_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        reg_idx_t    dest;
        reg_idx_t    src_a;
        reg_idx_t    src_b;
        shamt_t      shamt;
        word_t       imm;
        word_t       a;
        word_t       b;
        // Value of the dest register, for sw, bne/blt and jr
        word_t       c;
        word_t       pc_next;
        logic [26:0] target;
    } dx_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    result;
        word_t    store_data;
    } xm_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    result;
        word_t    load_data;
    } mw_t;

endpackage

`default_nettype wire

//--- src/fetch_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// Program counter and fetch/decode register
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fetch_unit (
    input  logic           clock,
    input  logic           arst_n,
    input  logic           stall,
    input  logic           redirect,
    input  cpu_pkg::word_t redirect_pc,
    input  cpu_pkg::word_t q_imem,
    output cpu_pkg::word_t address_imem,
    output cpu_pkg::fd_t   fd
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus_one;

    assign pc_plus_one  = pc + 32'd1;
    assign address_imem = pc;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            fd <= '0;
        end else if (redirect) begin
            // Squash the word in flight and restart at the target
            pc <= redirect_pc;
            fd <= '0;
        end else if (!stall) begin
            pc         <= pc_plus_one;
            fd.valid   <= 1'b1;
            fd.pc_next <= pc_plus_one;
            fd.insn    <= q_imem;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Field extraction and control decode
// Register-read addressing, decode/execute register
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module decode_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              redirect,
    input  cpu_pkg::fd_t      fd,
    output cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output cpu_pkg::reg_idx_t ctrl_read_reg_b,
    input  cpu_pkg::word_t    data_read_reg_a,
    input  cpu_pkg::word_t    data_read_reg_b,
    output cpu_pkg::dx_t      dx
);
    import cpu_pkg::*;

    logic [4:0] opcode;
    reg_idx_t   f_dest;
    reg_idx_t   f_src_a;
    reg_idx_t   f_src_b;
    imm_t       f_imm;
    ctrl_t      ctrl;
    logic       i_type;
    logic       dest_on_a;

    assign opcode  = fd.insn[31:27];
    assign f_dest  = fd.insn[26:22];
    assign f_src_a = fd.insn[21:17];
    assign f_src_b = fd.insn[16:12];
    assign f_imm   = fd.insn[16:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = fd.insn[6:2];
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            OP_BNE: ctrl.is_bne = 1'b1;
            OP_BLT: ctrl.is_blt = 1'b1;
            OP_J:   ctrl.is_jump = 1'b1;
            OP_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OP_JR:  ctrl.is_jr = 1'b1;
            default: ctrl = '0;
        endcase
    end

    // I-type and jr need dest on port A, src_a moves to port B
    assign i_type    = ctrl.use_imm | ctrl.is_bne | ctrl.is_blt;
    assign dest_on_a = i_type | ctrl.is_jr;

    assign ctrl_read_reg_a = dest_on_a ? f_dest : f_src_a;
    assign ctrl_read_reg_b = dest_on_a ? f_src_a : f_src_b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx <= '0;
        end else if (stall || redirect || !fd.valid) begin
            dx <= '0;
        end else begin
            dx.valid   <= 1'b1;
            dx.ctrl    <= ctrl;
            // Link register is the real destination of jal
            dx.dest    <= ctrl.is_jal ? REG_LINK : f_dest;
            dx.src_a   <= f_src_a;
            dx.src_b   <= f_src_b;
            dx.shamt   <= fd.insn[11:7];
            dx.imm     <= {{15{f_imm[16]}}, f_imm};
            dx.a       <= dest_on_a ? data_read_reg_b : data_read_reg_a;
            dx.b       <= data_read_reg_b;
            dx.c       <= data_read_reg_a;
            dx.pc_next <= fd.pc_next;
            dx.target  <= fd.insn[26:0];
        end
    end

endmodule

`default_nettype wire

//--- src/hazard_bypass.sv
// ~~~~~~~~~~~~~~~~~~~~
// Load-use stall detection
// Operand forwarding for execute
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module hazard_bypass (
    input  cpu_pkg::dx_t   dx,
    input  cpu_pkg::xm_t   xm,
    input  cpu_pkg::mw_t   mw,
    input  cpu_pkg::fd_t   fd,
    output logic           stall,
    output cpu_pkg::word_t fwd_a,
    output cpu_pkg::word_t fwd_b,
    output cpu_pkg::word_t fwd_c
);
    import cpu_pkg::*;

    logic [4:0] fd_op;
    logic       reads_dest;
    logic       reads_a;
    logic       reads_b;
    logic       load_live;

    // Youngest writer wins; a load in xm never meets a user here
    function automatic word_t bypass(input reg_idx_t r, input word_t dflt,
                                     input xm_t x, input mw_t m);
        word_t v;
        v = dflt;
        if (r != REG_ZERO) begin
            if (x.valid && x.ctrl.reg_write && !x.ctrl.mem_read && x.dest == r) begin
                v = x.result;
            end else if (m.valid && m.ctrl.reg_write && m.dest == r) begin
                v = m.ctrl.mem_read ? m.load_data : m.result;
            end
        end
        return v;
    endfunction

    assign fwd_a = bypass(dx.src_a, dx.a, xm, mw);
    assign fwd_b = bypass(dx.src_b, dx.b, xm, mw);
    assign fwd_c = bypass(dx.dest, dx.c, xm, mw);

    // Which fields the instruction in decode really reads
    assign fd_op = fd.insn[31:27];

    always_comb begin
        reads_dest = 1'b0;
        reads_a    = 1'b0;
        reads_b    = 1'b0;
        case (fd_op)
            OP_RTYPE: begin
                reads_a = 1'b1;
                reads_b = 1'b1;
            end
            OP_ADDI, OP_LW: reads_a = 1'b1;
            OP_SW, OP_BNE, OP_BLT: begin
                reads_a    = 1'b1;
                reads_dest = 1'b1;
            end
            OP_JR: reads_dest = 1'b1;
            default: reads_a = 1'b0;
        endcase
    end

    assign load_live = dx.valid && dx.ctrl.mem_read && (dx.dest != REG_ZERO);

    assign stall = load_live && fd.valid &&
                   ((reads_dest && fd.insn[26:22] == dx.dest) ||
                    (reads_a    && fd.insn[21:17] == dx.dest) ||
                    (reads_b    && fd.insn[16:12] == dx.dest));

endmodule

`default_nettype wire

//--- src/execute_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// ALU, branch and jump resolution
// Execute/memory register
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module execute_stage (
    input  logic           clock,
    input  logic           arst_n,
    input  cpu_pkg::dx_t   dx,
    input  cpu_pkg::word_t fwd_a,
    input  cpu_pkg::word_t fwd_b,
    input  cpu_pkg::word_t fwd_c,
    output logic           redirect,
    output cpu_pkg::word_t redirect_pc,
    output cpu_pkg::xm_t   xm
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_out;
    logic  taken;

    assign op_a = fwd_a;
    assign op_b = dx.ctrl.use_imm ? dx.imm : fwd_b;

    always_comb begin
        case (dx.ctrl.alu_op)
            ALU_ADD: alu_out = op_a + op_b;
            ALU_SUB: alu_out = op_a - op_b;
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_SLL: alu_out = op_a << dx.shamt;
            ALU_SRA: alu_out = word_t'($signed(op_a) >>> dx.shamt);
            default: alu_out = '0;
        endcase
    end

    // Branches compare rd against rs
    assign taken = (dx.ctrl.is_bne && (fwd_c != fwd_a)) ||
                   (dx.ctrl.is_blt && ($signed(fwd_c) < $signed(fwd_a)));

    assign redirect = dx.valid &&
                      (taken || dx.ctrl.is_jump || dx.ctrl.is_jal || dx.ctrl.is_jr);

    always_comb begin
        if (dx.ctrl.is_jr) begin
            redirect_pc = fwd_c;
        end else if (dx.ctrl.is_jump || dx.ctrl.is_jal) begin
            redirect_pc = {5'd0, dx.target};
        end else begin
            redirect_pc = dx.pc_next + dx.imm;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm <= '0;
        end else begin
            xm.valid      <= dx.valid;
            xm.ctrl       <= dx.ctrl;
            xm.dest       <= dx.dest;
            // jal carries its return address as the result
            xm.result     <= dx.ctrl.is_jal ? dx.pc_next : alu_out;
            xm.store_data <= fwd_c;
        end
    end

endmodule

`default_nettype wire

//--- src/mem_wb_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data memory ports, memory/writeback register
// Writeback select
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module mem_wb_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  cpu_pkg::xm_t      xm,
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data_dmem,
    output logic              wren,
    input  cpu_pkg::word_t    q_dmem,
    output cpu_pkg::mw_t      mw,
    output logic              ctrl_write_enable,
    output cpu_pkg::reg_idx_t ctrl_write_reg,
    output cpu_pkg::word_t    data_write_reg
);
    import cpu_pkg::*;

    assign address_dmem = xm.result;
    assign data_dmem    = xm.store_data;
    assign wren         = xm.valid && xm.ctrl.mem_write;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw.valid     <= xm.valid;
            mw.ctrl      <= xm.ctrl;
            mw.dest      <= xm.dest;
            mw.result    <= xm.result;
            mw.load_data <= q_dmem;
        end
    end

    // Decode already set dest to the link register for jal
    assign ctrl_write_reg = mw.dest;

    // Link value already sits in result for jal
    assign data_write_reg = mw.ctrl.mem_read ? mw.load_data : mw.result;

    // Writes to r0 are dropped here
    assign ctrl_write_enable = mw.valid && mw.ctrl.reg_write &&
                               (ctrl_write_reg != REG_ZERO);

endmodule

`default_nettype wire

//--- src/pipeline_cpu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Five-stage core top level
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pipeline_cpu (
    input  logic              clock,
    input  logic              arst_n,
    // Instruction memory
    output cpu_pkg::word_t    address_imem,
    input  cpu_pkg::word_t    q_imem,
    // Data memory
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data_dmem,
    output logic              wren,
    input  cpu_pkg::word_t    q_dmem,
    // Register file with same-cycle write-through reads
    output logic              ctrl_write_enable,
    output cpu_pkg::reg_idx_t ctrl_write_reg,
    output cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output cpu_pkg::reg_idx_t ctrl_read_reg_b,
    output cpu_pkg::word_t    data_write_reg,
    input  cpu_pkg::word_t    data_read_reg_a,
    input  cpu_pkg::word_t    data_read_reg_b
);
    import cpu_pkg::*;

    fd_t   fd;
    dx_t   dx;
    xm_t   xm;
    mw_t   mw;
    logic  stall;
    logic  redirect;
    word_t redirect_pc;
    word_t fwd_a;
    word_t fwd_b;
    word_t fwd_c;

    fetch_unit u_fetch (
        .clock        (clock),
        .arst_n       (arst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd           (fd)
    );

    decode_stage u_decode (
        .clock           (clock),
        .arst_n          (arst_n),
        .stall           (stall),
        .redirect        (redirect),
        .fd              (fd),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .dx              (dx)
    );

    hazard_bypass u_hazard (
        .dx    (dx),
        .xm    (xm),
        .mw    (mw),
        .fd    (fd),
        .stall (stall),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b),
        .fwd_c (fwd_c)
    );

    execute_stage u_execute (
        .clock       (clock),
        .arst_n      (arst_n),
        .dx          (dx),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fwd_c       (fwd_c),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm          (xm)
    );

    mem_wb_stage u_mem_wb (
        .clock             (clock),
        .arst_n            (arst_n),
        .xm                (xm),
        .address_dmem      (address_dmem),
        .data_dmem         (data_dmem),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .mw                (mw),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg)
    );

endmodule

`default_nettype wire

//--- tests/pipeline_cpu_sva.sv
// ~~~~~~~~~~~~~~~~~~~~
// Assertions on the core's outward controls
// Bound into pipeline_cpu
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pipeline_cpu_sva (
    input logic              clock,
    input logic              arst_n,
    input logic              stall,
    input logic              wren,
    input logic              ctrl_write_enable,
    input cpu_pkg::reg_idx_t ctrl_write_reg,
    input cpu_pkg::word_t    address_imem
);
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    // Read by the testbench at the end of each cycle
    int fail_count = 0;

    no_write_to_r0: assert property (@(posedge clock) disable iff (!arst_n)
        ctrl_write_enable |-> ctrl_write_reg != REG_ZERO)
        else begin
            fail_count++;
            $error("register write enabled with r0 as destination");
        end

    quiet_in_reset: assert property (@(posedge clock)
        !arst_n |-> (!wren && !ctrl_write_enable))
        else begin
            fail_count++;
            $error("write or store strobe high during reset");
        end

    // Fetch holds its PC for the stalled cycle
    pc_holds_on_stall: assert property (@(posedge clock) disable iff (!arst_n)
        stall |=> $stable(address_imem))
        else begin
            fail_count++;
            $error("instruction address moved after a stall");
        end

endmodule

bind pipeline_cpu pipeline_cpu_sva u_checks (
    .clock             (clock),
    .arst_n            (arst_n),
    .stall             (stall),
    .wren              (wren),
    .ctrl_write_enable (ctrl_write_enable),
    .ctrl_write_reg    (ctrl_write_reg),
    .address_imem      (address_imem)
);

`default_nettype wire

//--- tests/pipeline_cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the five-stage core
// Clock, reset, memory and register-file models
// Trace loading, write and store checking
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module pipeline_cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam string TRACE_PATH        = "tests/program_trace.txt";
    localparam int    TRACE_WORDS       = 600;
    localparam int    MEM_WORDS         = 256;
    localparam int    RESET_CYCLES      = 10;
    localparam int    FIRST_WRITE_CYCLE = 4;
    localparam int    DRAIN_CYCLES      = 8;

    // Tags in the first column of the trace
    localparam word_t TAG_PROG  = 32'h1;
    localparam word_t TAG_WRITE = 32'h2;
    localparam word_t TAG_STORE = 32'h3;

    typedef struct packed {
        logic  is_store;
        word_t key;
        word_t value;
    } expect_t;

    logic     clock;
    logic     arst_n;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data_dmem;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_write_enable;
    reg_idx_t ctrl_write_reg;
    reg_idx_t ctrl_read_reg_a;
    reg_idx_t ctrl_read_reg_b;
    word_t    data_write_reg;
    word_t    data_read_reg_a;
    word_t    data_read_reg_b;

    word_t   trace_mem [0:TRACE_WORDS-1];
    word_t   imem [0:MEM_WORDS-1];
    word_t   dmem [0:MEM_WORDS-1];
    word_t   regs [0:31];
    expect_t expected [$];
    int      prog_len;
    int      timeout_limit;
    int      cycle_count;
    logic    seen_first;

    pipeline_cpu uut (
        .clock             (clock),
        .arst_n            (arst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data_dmem         (data_dmem),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    // Memories answer in the same cycle
    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    // Register file with write-through and r0 tied to zero
    assign data_read_reg_a = (ctrl_read_reg_a == REG_ZERO) ? '0 :
                             (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ?
                             data_write_reg : regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == REG_ZERO) ? '0 :
                             (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ?
                             data_write_reg : regs[ctrl_read_reg_b];

    always @(posedge clock) begin
        if (ctrl_write_enable && ctrl_write_reg != REG_ZERO) begin
            regs[ctrl_write_reg] <= data_write_reg;
        end
        if (wren) begin
            dmem[address_dmem[7:0]] <= data_dmem;
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
            stop_with_failure("Check failed, run stopped at the first mismatch");
        end
    endtask

    task automatic check_record(input logic is_store, input word_t key, input word_t value);
        expect_t rec;
        if (expected.size() == 0) begin
            stop_with_failure("Write or store seen after the last expected record");
        end else begin
            rec = expected.pop_front();
            if (rec.is_store != is_store) begin
                stop_with_failure("Write and store arrived in the wrong order");
            end else if (is_store) begin
                check_value("address_dmem", key, rec.key);
                check_value("data_dmem", value, rec.value);
            end else begin
                check_value("ctrl_write_reg", key, rec.key);
                check_value("data_write_reg", value, rec.value);
            end
        end
    endtask

    task automatic load_trace();
        int    i;
        word_t tag;
        logic  done;
        for (i = 0; i < TRACE_WORDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh(TRACE_PATH, trace_mem);
        i    = 0;
        done = 1'b0;
        while (!done && i + 2 < TRACE_WORDS) begin
            tag = trace_mem[i];
            if (tag == '0) begin
                done = 1'b1;
            end else if (tag == TAG_PROG) begin
                imem[trace_mem[i+1][7:0]] = trace_mem[i+2];
                prog_len++;
            end else if (tag == TAG_WRITE) begin
                expected.push_back('{1'b0, trace_mem[i+1], trace_mem[i+2]});
            end else if (tag == TAG_STORE) begin
                expected.push_back('{1'b1, trace_mem[i+1], trace_mem[i+2]});
            end else begin
                stop_with_failure("Trace file holds an unknown tag");
            end
            i += 3;
        end
        if (prog_len == 0 || expected.size() == 0) begin
            stop_with_failure("Trace file holds no program or no expected records");
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Outputs are stable at the falling edge
    always @(negedge clock) begin
        if (arst_n) begin
            if (uut.u_checks.fail_count != 0) begin
                stop_with_failure("A bound assertion on the core failed");
            end
            if ((ctrl_write_enable || wren) && !seen_first) begin
                seen_first = 1'b1;
                check_value("first write cycle", word_t'(cycle_count), FIRST_WRITE_CYCLE);
            end
            // The older instruction sits in writeback, so its record comes first
            if (ctrl_write_enable) begin
                check_record(1'b0, word_t'(ctrl_write_reg), data_write_reg);
            end
            if (wren) begin
                check_record(1'b1, address_dmem, data_dmem);
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        cycle_count = 0;
        seen_first  = 1'b0;
        prog_len    = 0;
        for (int k = 0; k < MEM_WORDS; k++) begin
            imem[k] = '0;
            // Each fill word carries its own address
            dmem[k] = 32'hd0d0_0000 | word_t'(k);
        end
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        load_trace();
        timeout_limit = 4 * prog_len + 100;

        repeat (RESET_CYCLES) @(negedge clock);
        arst_n = 1'b1;
        check_value("address_imem", address_imem, '0);

        while (expected.size() != 0 && cycle_count < timeout_limit) begin
            @(posedge clock);
            cycle_count++;
        end

        if (expected.size() != 0) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d records left",
                                        cycle_count, expected.size()));
        end else begin
            // Any late write during the drain has no record left and fails
            repeat (DRAIN_CYCLES) @(posedge clock);
            if (uut.u_checks.fail_count == 0) begin
                $display("TEST RESULT: PASS");
                $finish;
            end else begin
                stop_with_failure("A bound assertion on the core failed");
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/program_trace.txt
// Columns: tag key value, all hex. Tag 1 loads value as the program word at address key,
// tag 2 expects value written to register key, tag 3 expects value stored at address key.
1 00 28400005 // addi r1, r0, 5
1 01 28820003 // addi r2, r1, 3
1 02 00c22000 // add  r3, r1, r2
1 03 01061004 // sub  r4, r3, r1
1 04 01483008 // and  r5, r4, r3
1 05 018a100c // or   r6, r5, r1
1 06 29c1fff0 // addi r7, r0, -16
1 07 02020210 // sll  r8, r1, 4
1 08 024e0114 // sra  r9, r7, 2
1 09 39820004 // sw   r6, 4(r1)
1 0a 42820004 // lw   r10, 4(r1)
1 0b 02d41000 // add  r11, r10, r1, load-use
1 0c 10420005 // bne  r1, r1, +5, not taken
1 0d 31c20002 // blt  r7, r1, +2, taken to 16
1 0e 2b000001 // addi r12, squashed
1 0f 2b000002 // addi r12, squashed
1 10 10440001 // bne  r1, r2, +1, taken to 18
1 11 2b400007 // addi r13, squashed
1 12 304e0001 // blt  r1, r7, +1, not taken
1 13 18000017 // jal  23
1 14 0800001b // j    27
1 15 2b800009 // addi r14, squashed
1 16 2b80000a // addi r14, squashed
1 17 2bc00033 // addi r15, r0, 0x33
1 18 27c00000 // jr   r31
1 19 2c000001 // addi r16, squashed
1 1a 2c800002 // addi r18, squashed
1 1b 2c400044 // addi r17, r0, 0x44
1 1c 3c400020 // sw   r17, 0x20(r0)
1 1d 0800001d // j    29, loop
2 01 00000005
2 02 00000008
2 03 0000000d
2 04 00000008
2 05 00000008
2 06 0000000d
2 07 fffffff0
2 08 00000050
2 09 fffffffc
3 09 0000000d
2 0a 0000000d
2 0b 00000012
2 1f 00000014
2 0f 00000033
2 11 00000044
3 20 00000044

//--- vlog.f
src/cpu_pkg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/hazard_bypass.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/pipeline_cpu.sv
tests/pipeline_cpu_sva.sv
tests/pipeline_cpu_tb.sv

//--- Makefile
# Verilator build, run and lint for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= pipeline_cpu_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
